//--- logic/id_cfg.svh
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// datapath widths
`define ID_DATA_W    32
`define ID_REG_AW    5
`define ID_REG_NUM   32   // general purpose registers

// exception cause codes matching Cause.ExcCode
`define ID_EXC_W     5
`define ID_EXC_SYS   5'd8
`define ID_EXC_BP    5'd9
`define ID_EXC_RI    5'd10   // reserved instruction

// fixed register numbers
`define ID_LINK_REG  5'd31   // jal return address

`endif

//--- logic/id_pkg.sv
`include "id_cfg.svh"

package id_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
        OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
        OP_LW      = 6'h23, OP_SW     = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00, FN_SRL     = 6'h02, FN_SRA   = 6'h03, FN_SLLV = 6'h04,
        FN_SRLV = 6'h06, FN_SRAV    = 6'h07, FN_JR    = 6'h08, FN_JALR = 6'h09,
        FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d, FN_ADD  = 6'h20, FN_ADDU = 6'h21,
        FN_SUB  = 6'h22, FN_SUBU    = 6'h23, FN_AND   = 6'h24, FN_OR   = 6'h25,
        FN_XOR  = 6'h26, FN_NOR     = 6'h27, FN_SLT   = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {IMM_NONE, IMM_ZERO, IMM_SIGN} imm_sel_e;   // src2 source

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_GEZ, BR_GTZ, BR_LEZ, BR_LTZ,
        BR_JR,   // jr, jalr
        BR_J     // j, jal
    } br_kind_e;

    typedef struct packed {
        logic [`ID_DATA_W-1:0] inst;
        logic [`ID_DATA_W-1:0] pc;
        logic                  exc;
        logic [`ID_EXC_W-1:0]  exc_code;
        logic                  bd;        // in a delay slot
    } fetch_bundle_t;

    typedef struct packed {
        logic                  we;
        logic [`ID_REG_AW-1:0] addr;
        logic [`ID_DATA_W-1:0] data;
    } wb_write_t;

    typedef struct packed {
        logic [`ID_REG_AW-1:0] dest;      // zero when the stage writes nothing
        logic [`ID_DATA_W-1:0] result;
        logic                  load;      // meaningful on the exe source
    } fwd_source_t;

    typedef struct packed {
        alu_op_e               alu_op;
        logic                  load;
        logic                  mem_we;
        logic                  gr_we;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        imm_sel_e              imm_sel;
        logic                  src2_is_8;
        logic                  uses_rt;
        logic [`ID_REG_AW-1:0] dest;
        logic [15:0]           imm;
        br_kind_e              br_kind;
        logic [25:0]           jidx;
        logic                  ex;
        logic [`ID_EXC_W-1:0]  exc_code;
    } decode_ctrl_t;

    typedef struct packed {
        logic [`ID_DATA_W-1:0] rs;
        logic [`ID_DATA_W-1:0] rt;
    } operands_t;

    typedef struct packed {
        logic                  valid;
        logic                  taken;
        logic [`ID_DATA_W-1:0] target;
    } branch_bus_t;

    typedef struct packed {
        decode_ctrl_t          ctrl;
        operands_t             ops;
        logic                  bd;
        logic [`ID_DATA_W-1:0] pc;
    } exec_bundle_t;

endpackage

//--- logic/regfile.sv
`timescale 1ns/1ns
`include "id_cfg.svh"

module regfile (
    input  logic                  clk,
    input  logic [`ID_REG_AW-1:0] raddr1,
    input  logic [`ID_REG_AW-1:0] raddr2,
    output logic [`ID_DATA_W-1:0] rdata1,
    output logic [`ID_DATA_W-1:0] rdata2,
    input  id_pkg::wb_write_t     wr
);

    logic [`ID_DATA_W-1:0] regs [`ID_REG_NUM];

    // single write port from write-back
    always_ff @(posedge clk) begin
        if (wr.we && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // $0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ns
`include "id_cfg.svh"

module inst_decoder (
    input  logic [`ID_DATA_W-1:0] inst,
    input  logic                  fetch_exc,
    input  logic [`ID_EXC_W-1:0]  fetch_exc_code,
    output id_pkg::decode_ctrl_t  ctrl
);
    import id_pkg::*;

    opcode_e               op;
    funct_e                fn;
    logic [`ID_REG_AW-1:0] rs;
    logic [`ID_REG_AW-1:0] rt;
    logic [`ID_REG_AW-1:0] rd;
    logic [4:0]            sa;
    logic                  known;       // word belongs to the supported subset
    logic                  is_syscall;
    logic                  is_break;
    logic                  dst_is_rt;
    logic                  dst_is_r31;

    assign op = opcode_e'(inst[31:26]);
    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign rd = inst[15:11];
    assign sa = inst[10:6];
    assign fn = funct_e'(inst[5:0]);

    always_comb begin
        known      = 1'b1;
        is_syscall = 1'b0;
        is_break   = 1'b0;
        dst_is_rt  = 1'b0;
        dst_is_r31 = 1'b0;
        ctrl          = '0;
        ctrl.alu_op   = ALU_ADD;            // also address and link adds
        ctrl.imm_sel  = IMM_NONE;
        ctrl.br_kind  = BR_NONE;
        ctrl.gr_we    = 1'b1;
        ctrl.uses_rt  = 1'b1;
        ctrl.imm      = inst[15:0];
        ctrl.jidx     = inst[25:0];

        case (op)
            OP_SPECIAL: begin
                known = (sa == '0);             // most R-type words need sa zero
                case (fn)
                    FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_SLT:          ctrl.alu_op = ALU_SLT;
                    FN_SLTU:         ctrl.alu_op = ALU_SLTU;
                    FN_AND:          ctrl.alu_op = ALU_AND;
                    FN_OR:           ctrl.alu_op = ALU_OR;
                    FN_XOR:          ctrl.alu_op = ALU_XOR;
                    FN_NOR:          ctrl.alu_op = ALU_NOR;
                    FN_SLLV:         ctrl.alu_op = ALU_SLL;
                    FN_SRLV:         ctrl.alu_op = ALU_SRL;
                    FN_SRAV:         ctrl.alu_op = ALU_SRA;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        ctrl.alu_op     = (fn == FN_SLL) ? ALU_SLL :
                                          (fn == FN_SRL) ? ALU_SRL : ALU_SRA;
                        ctrl.src1_is_sa = 1'b1;
                        known           = (rs == '0);   // sa carries the amount
                    end
                    FN_JR: begin
                        ctrl.br_kind = BR_JR;
                        ctrl.gr_we   = 1'b0;
                        ctrl.uses_rt = 1'b0;
                        known        = (sa == '0) && (rt == '0) && (rd == '0);
                    end
                    FN_JALR: begin
                        ctrl.br_kind    = BR_JR;
                        ctrl.src1_is_pc = 1'b1;         // link value is pc + 8
                        ctrl.src2_is_8  = 1'b1;
                        ctrl.uses_rt    = 1'b0;
                        known           = (sa == '0) && (rt == '0);
                    end
                    FN_SYSCALL, FN_BREAK: begin
                        is_syscall = (fn == FN_SYSCALL);
                        is_break   = (fn == FN_BREAK);
                        known      = 1'b1;              // code field is free
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_REGIMM: begin
                ctrl.br_kind = (rt == 5'd1) ? BR_GEZ : BR_LTZ;
                known        = (rt == 5'd1) || (rt == 5'd0);
            end
            OP_J, OP_JAL: begin
                ctrl.br_kind    = BR_J;
                ctrl.gr_we      = (op == OP_JAL);
                ctrl.src1_is_pc = (op == OP_JAL);
                ctrl.src2_is_8  = (op == OP_JAL);
                dst_is_r31      = 1'b1;
            end
            OP_BEQ:  ctrl.br_kind = BR_EQ;
            OP_BNE:  ctrl.br_kind = BR_NE;
            OP_BLEZ, OP_BGTZ: begin
                ctrl.br_kind = (op == OP_BLEZ) ? BR_LEZ : BR_GTZ;
                known        = (rt == '0);
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LW: begin
                ctrl.alu_op  = (op == OP_SLTI)  ? ALU_SLT  :
                               (op == OP_SLTIU) ? ALU_SLTU : ALU_ADD;
                ctrl.imm_sel = IMM_SIGN;
                ctrl.load    = (op == OP_LW);
                dst_is_rt    = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.alu_op  = (op == OP_ANDI) ? ALU_AND :
                               (op == OP_ORI)  ? ALU_OR  :
                               (op == OP_XORI) ? ALU_XOR : ALU_LUI;
                ctrl.imm_sel = IMM_ZERO;
                dst_is_rt    = 1'b1;
                known        = (op != OP_LUI) || (rs == '0);
            end
            OP_SW: begin
                ctrl.imm_sel = IMM_SIGN;
                ctrl.mem_we  = 1'b1;
            end
            default: known = 1'b0;
        endcase

        // rt is only a source for reg-reg ops, stores and beq/bne
        if (dst_is_rt || (ctrl.br_kind inside {BR_GEZ, BR_GTZ, BR_LEZ, BR_LTZ, BR_J})) begin
            ctrl.uses_rt = 1'b0;
        end
        if (ctrl.br_kind inside {BR_EQ, BR_NE, BR_GEZ, BR_GTZ, BR_LEZ, BR_LTZ}) begin
            ctrl.gr_we = 1'b0;
        end

        // fetch fault wins, then RI, syscall, break
        ctrl.ex = fetch_exc || !known || is_syscall || is_break;
        ctrl.exc_code = fetch_exc  ? fetch_exc_code :
                        !known     ? `ID_EXC_RI     :
                        is_syscall ? `ID_EXC_SYS    :
                        is_break   ? `ID_EXC_BP     : '0;

        if (ctrl.ex || ctrl.mem_we) begin
            ctrl.gr_we = 1'b0;
        end
        if (ctrl.ex) begin
            ctrl.mem_we  = 1'b0;
            ctrl.load    = 1'b0;
            ctrl.br_kind = BR_NONE;
        end

        ctrl.dest = !ctrl.gr_we ? '0           :
                    dst_is_r31  ? `ID_LINK_REG :
                    dst_is_rt   ? rt           : rd;
    end

endmodule

//--- logic/operand_forward.sv
`timescale 1ns/1ns
`include "id_cfg.svh"

module operand_forward (
    input  logic                  [`ID_REG_AW-1:0] rs,
    input  logic                  [`ID_REG_AW-1:0] rt,
    input  logic                  uses_rt,
    input  id_pkg::wb_write_t     wr,
    input  id_pkg::fwd_source_t   exe,
    input  id_pkg::fwd_source_t   mem,
    input  id_pkg::fwd_source_t   wb,
    input  logic                  clk,
    output id_pkg::operands_t     ops,
    output logic                  load_hazard
);
    import id_pkg::*;

    logic [`ID_DATA_W-1:0] rf_rs;
    logic [`ID_DATA_W-1:0] rf_rt;
    logic                  rs_on_exe;
    logic                  rt_on_exe;

    // youngest producer wins
    function automatic logic [`ID_DATA_W-1:0] pick_source(
        input logic [`ID_REG_AW-1:0] addr,
        input logic [`ID_DATA_W-1:0] rf_value,
        input fwd_source_t           e,
        input fwd_source_t           m,
        input fwd_source_t           w
    );
        logic [`ID_DATA_W-1:0] value;
        value = rf_value;
        if (addr != '0) begin
            if (addr == e.dest) begin
                value = e.result;
            end else if (addr == m.dest) begin
                value = m.result;
            end else if (addr == w.dest) begin
                value = w.result;   // covers the write landing this edge
            end
        end
        return value;
    endfunction

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt),
        .wr     (wr)
    );

    assign ops.rs = pick_source(rs, rf_rs, exe, mem, wb);
    assign ops.rt = pick_source(rt, rf_rt, exe, mem, wb);

    // load data is not ready before mem, so wait a cycle
    assign rs_on_exe   = (rs != '0) && (rs == exe.dest);
    assign rt_on_exe   = (rt != '0) && (rt == exe.dest) && uses_rt;
    assign load_hazard = exe.load && (rs_on_exe || rt_on_exe);

endmodule

//--- logic/issue_control.sv
`timescale 1ns/1ns
`include "id_cfg.svh"

module issue_control (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  fetch_valid,
    input  id_pkg::fetch_bundle_t fetch,
    output logic                  allowin,
    output id_pkg::fetch_bundle_t latched,
    input  id_pkg::decode_ctrl_t  ctrl,
    input  id_pkg::operands_t     ops,
    input  logic                  load_hazard,
    input  logic                  exec_allowin,
    output logic                  exec_valid,
    output id_pkg::exec_bundle_t  exec,
    output id_pkg::branch_bus_t   br
);
    import id_pkg::*;

    logic                  valid;       // stage holds an instruction
    logic                  ready_go;
    logic [`ID_DATA_W-1:0] pc_next;     // delay slot pc
    logic [`ID_DATA_W-1:0] br_offset;
    logic                  rs_eq_rt;
    logic                  rs_zero;
    logic                  rs_neg;

    assign ready_go   = !load_hazard;
    assign allowin    = !valid || (ready_go && exec_allowin);
    assign exec_valid = valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && allowin) begin
            latched <= fetch;
        end
    end

    assign pc_next   = latched.pc + `ID_DATA_W'(4);
    assign br_offset = {{(`ID_DATA_W - 18){ctrl.imm[15]}}, ctrl.imm, 2'b00};
    assign rs_eq_rt  = (ops.rs == ops.rt);
    assign rs_zero   = (ops.rs == '0);
    assign rs_neg    = ops.rs[`ID_DATA_W-1];

    always_comb begin
        // only resolved once operands are final
        br.valid = valid && ready_go && (ctrl.br_kind != BR_NONE);
        case (ctrl.br_kind)
            BR_EQ:       br.taken = rs_eq_rt;
            BR_NE:       br.taken = !rs_eq_rt;
            BR_GEZ:      br.taken = !rs_neg;
            BR_GTZ:      br.taken = !rs_neg && !rs_zero;
            BR_LEZ:      br.taken = rs_neg || rs_zero;
            BR_LTZ:      br.taken = rs_neg;
            BR_JR, BR_J: br.taken = 1'b1;
            default:     br.taken = 1'b0;
        endcase
        case (ctrl.br_kind)
            BR_JR:   br.target = ops.rs;
            BR_J:    br.target = {pc_next[`ID_DATA_W-1:28], ctrl.jidx, 2'b00};
            default: br.target = pc_next + br_offset;
        endcase
    end

    assign exec = '{ctrl: ctrl, ops: ops, bd: latched.bd, pc: latched.pc};

endmodule

//--- logic/id_stage.sv
`timescale 1ns/1ns

module id_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  fetch_valid,
    input  id_pkg::fetch_bundle_t fetch,
    output logic                  allowin,
    input  logic                  exec_allowin,
    output logic                  exec_valid,
    output id_pkg::exec_bundle_t  exec,
    output id_pkg::branch_bus_t   br,
    input  id_pkg::wb_write_t     wr,
    input  id_pkg::fwd_source_t   exe,
    input  id_pkg::fwd_source_t   mem,
    input  id_pkg::fwd_source_t   wb
);
    import id_pkg::*;

    fetch_bundle_t latched;      // stage register contents
    decode_ctrl_t  ctrl;
    operands_t     ops;
    logic          load_hazard;

    issue_control u_issue (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .fetch_valid  (fetch_valid),
        .fetch        (fetch),
        .allowin      (allowin),
        .latched      (latched),
        .ctrl         (ctrl),
        .ops          (ops),
        .load_hazard  (load_hazard),
        .exec_allowin (exec_allowin),
        .exec_valid   (exec_valid),
        .exec         (exec),
        .br           (br)
    );

    inst_decoder u_decoder (
        .inst           (latched.inst),
        .fetch_exc      (latched.exc),
        .fetch_exc_code (latched.exc_code),
        .ctrl           (ctrl)
    );

    operand_forward u_forward (
        .rs          (latched.inst[25:21]),
        .rt          (latched.inst[20:16]),
        .uses_rt     (ctrl.uses_rt),
        .wr          (wr),
        .exe         (exe),
        .mem         (mem),
        .wb          (wb),
        .clk         (clk),
        .ops         (ops),
        .load_hazard (load_hazard)
    );

endmodule

//--- verification/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage;
    import id_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_VEC      = 30;
    localparam int VEC_W        = 28;   // words per vector line
    localparam int EXP_BASE     = 17;   // first expected word in a vector

    logic          clk;
    logic          reset;
    logic          flush;
    logic          fetch_valid;
    fetch_bundle_t fetch;
    logic          allowin;
    logic          exec_allowin;
    logic          exec_valid;
    exec_bundle_t  exec;
    branch_bus_t   br;
    wb_write_t     wr;
    fwd_source_t   exe;
    fwd_source_t   mem;
    fwd_source_t   wb;

    logic [31:0]   vec_mem [NUM_VEC*VEC_W];
    logic [31:0]   held_pc;             // pc of the item the stage should hold

    id_stage uut (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .fetch_valid  (fetch_valid),
        .fetch        (fetch),
        .allowin      (allowin),
        .exec_allowin (exec_allowin),
        .exec_valid   (exec_valid),
        .exec         (exec),
        .br           (br),
        .wr           (wr),
        .exe          (exe),
        .mem          (mem),
        .wb           (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // one vector line onto the DUT inputs
    task automatic apply_vector(input int n);
        int b;
        b = n * VEC_W;
        fetch_valid    = vec_mem[b][0];
        fetch.exc      = vec_mem[b+1][0];
        fetch.exc_code = vec_mem[b+2][4:0];
        fetch.bd       = 1'b0;
        exec_allowin   = vec_mem[b+3][0];
        flush          = vec_mem[b+4][0];
        wr.we          = vec_mem[b+5][0];
        wr.addr        = vec_mem[b+6][4:0];
        wr.data        = vec_mem[b+7];
        fetch.inst     = vec_mem[b+8];
        fetch.pc       = vec_mem[b+9];
        exe.dest       = vec_mem[b+10][4:0];
        exe.result     = vec_mem[b+11];
        exe.load       = vec_mem[b+12][0];
        mem.dest       = vec_mem[b+13][4:0];
        mem.result     = vec_mem[b+14];
        mem.load       = 1'b0;
        wb.dest        = vec_mem[b+15][4:0];
        wb.result      = vec_mem[b+16];
        wb.load        = 1'b0;
    endtask

    task automatic check_value(input int n, input string what,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: vector %0d %s is %h, expected %h",
                     $time, n, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_vector(input int n, input logic [31:0] exp_pc);
        int         b;
        logic [2:0] we_flags;
        b = n * VEC_W + EXP_BASE;
        check_value(n, "exec_valid", exec_valid, vec_mem[b]);
        check_value(n, "allowin", allowin, vec_mem[b+1]);
        check_value(n, "branch valid", br.valid, vec_mem[b+2]);
        if (vec_mem[b][0]) begin   // fields only mean something on a valid item
            we_flags = {exec.ctrl.load, exec.ctrl.mem_we, exec.ctrl.gr_we};
            check_value(n, "pc", exec.pc, exp_pc);
            check_value(n, "dest", exec.ctrl.dest, vec_mem[b+3]);
            check_value(n, "rs value", exec.ops.rs, vec_mem[b+4]);
            check_value(n, "rt value", exec.ops.rt, vec_mem[b+5]);
            check_value(n, "alu op", exec.ctrl.alu_op, vec_mem[b+6]);
            check_value(n, "write enables", we_flags, vec_mem[b+7]);
            check_value(n, "branch taken", br.taken, vec_mem[b+8]);
            if (vec_mem[b+8][0]) begin
                check_value(n, "branch target", br.target, vec_mem[b+9]);
            end
            check_value(n, "exception code", exec.ctrl.exc_code, vec_mem[b+10]);
        end
    endtask

    initial begin
        #(CLK_PERIOD * (NUM_VEC * 4 + RESET_CYCLES));
        $display("Watchdog expired at %0t ns, the run hung", $time);
        $display("TESTS FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        held_pc      = '0;
        reset        = 1'b1;
        flush        = 1'b0;
        fetch_valid  = 1'b0;
        fetch        = '0;
        exec_allowin = 1'b1;
        wr           = '0;
        exe          = '0;
        mem          = '0;
        wb           = '0;
        $readmemh("verification/id_stimulus.mem", vec_mem);
        if ($isunknown(vec_mem[NUM_VEC*VEC_W-1])) begin
            $display("Stimulus file verification/id_stimulus.mem could not be read");
            $display("TESTS FAILED");
            $fatal(1, "no stimulus");
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // drive 1 ns after the edge, sample 1 ns before the next one
        for (int i = 0; i < NUM_VEC; i++) begin
            apply_vector(i);
            #2;
            check_vector(i, held_pc);
            // accepted on the coming edge when fetch_valid meets allowin
            if (vec_mem[i*VEC_W][0] && vec_mem[i*VEC_W+EXP_BASE+1][0]) begin
                held_pc = vec_mem[i*VEC_W+9];
            end
            @(posedge clk);
            #1;
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- project.f
+incdir+logic
logic/id_pkg.sv
logic/regfile.sv
logic/inst_decoder.sv
logic/operand_forward.sv
logic/issue_control.sv
logic/id_stage.sv
verification/tb_id_stage.sv

//--- verification/id_stimulus.mem
// in: fv fexc fcode exec_allowin flush we waddr wdata inst pc exe_dst exe_res exe_ld mem_dst mem_res wb_dst wb_res
// exp (item latched on the previous edge): ev allowin bvalid dest rs rt alu we(ld,st,gr) taken target exc
0 0 0 1 0 1 1 11111111 0 0 0 0 0 0 0 0 0  0 1 0 0 0 0 0 0 0 0 0
0 0 0 1 0 1 2 22 0 0 0 0 0 0 0 0 0  0 1 0 0 0 0 0 0 0 0 0
0 0 0 1 0 1 3 11111111 0 0 0 0 0 0 0 0 0  0 1 0 0 0 0 0 0 0 0 0
0 0 0 1 0 1 4 fffffff0 0 0 0 0 0 0 0 0 0  0 1 0 0 0 0 0 0 0 0 0
1 0 0 1 0 1 5 00400100 00223021 bfc00000 0 0 0 0 0 0 0  0 1 0 0 0 0 0 0 0 0 0
1 0 0 1 0 0 0 0 24430010 bfc00004 0 0 0 0 0 0 0  1 1 0 6 11111111 22 0 1 0 0 0
1 0 0 1 0 0 0 0 8c220008 bfc00008 0 0 0 0 0 0 0  1 1 0 3 22 11111111 0 1 0 0 0
1 0 0 1 0 0 0 0 ac220004 bfc0000c 0 0 0 0 0 0 0  1 1 0 2 11111111 22 0 5 0 0 0
1 0 0 1 0 0 0 0 00224825 bfc00010 0 0 0 0 0 0 0  1 1 0 0 11111111 22 0 2 0 0 0
1 0 0 1 0 0 0 0 00224825 bfc00014 1 aa01 0 1 bb01 2 cc02  1 1 0 9 aa01 cc02 6 1 0 0 0
1 0 0 1 0 0 0 0 00024825 bfc00018 2 aa02 0 1 bb01 1 cc01  1 1 0 9 bb01 aa02 6 1 0 0 0
1 0 0 1 0 0 0 0 00225023 bfc0001c 0 dd00 0 0 ee00 2 cc02  1 1 0 9 0 cc02 6 1 0 0 0
1 0 0 1 0 0 0 0 10230004 bfc00020 1 ee01 1 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0
1 0 0 1 0 0 0 0 10230004 bfc00020 0 0 0 0 0 0 0  1 1 0 a 11111111 22 1 1 0 0 0
1 0 0 1 0 0 0 0 14230008 bfc00024 0 0 0 0 0 0 0  1 1 1 0 11111111 11111111 0 0 1 bfc00034 0
1 0 0 1 0 0 0 0 0481fffe bfc00028 0 0 0 0 0 0 0  1 1 1 0 11111111 11111111 0 0 0 0 0
1 0 0 1 0 0 0 0 0480fffe bfc0002c 0 0 0 0 0 0 0  1 1 1 0 fffffff0 11111111 0 0 0 0 0
1 0 0 1 0 0 0 0 08010040 bfc00030 0 0 0 0 0 0 0  1 1 1 0 fffffff0 0 0 0 1 bfc00028 0
1 0 0 1 0 0 0 0 0c020080 bfc00034 0 0 0 0 0 0 0  1 1 1 0 0 11111111 0 0 1 b0040100 0
1 0 0 1 0 0 0 0 00a00008 bfc00038 0 0 0 0 0 0 0  1 1 1 1f 0 22 0 1 1 b0080200 0
1 0 0 1 0 0 0 0 fc000000 bfc0003c 0 0 0 0 0 0 0  1 1 1 0 00400100 0 0 0 1 00400100 0
1 0 0 1 0 0 0 0 0000000c bfc00040 0 0 0 0 0 0 0  1 1 0 0 0 0 0 0 0 0 a
1 0 0 1 0 0 0 0 0000000d bfc00044 0 0 0 0 0 0 0  1 1 0 0 0 0 0 0 0 0 8
1 1 4 1 0 0 0 0 0000000c bfc00045 0 0 0 0 0 0 0  1 1 0 0 0 0 0 0 0 0 9
1 0 0 1 0 0 0 0 00223021 bfc00048 0 0 0 0 0 0 0  1 1 0 0 0 0 0 0 0 0 4
1 0 0 0 0 0 0 0 00224825 bfc0004c 0 0 0 0 0 0 0  1 0 0 6 11111111 22 0 1 0 0 0
1 0 0 0 0 0 0 0 00224825 bfc0004c 0 0 0 0 0 0 0  1 0 0 6 11111111 22 0 1 0 0 0
1 0 0 1 0 0 0 0 00224825 bfc0004c 0 0 0 0 0 0 0  1 1 0 6 11111111 22 0 1 0 0 0
0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0  1 0 0 9 11111111 22 6 1 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 1 0 0 0 0 0 0 0 0 0
